// File: prefetchPkg.sv
// shared types for the read prefetcher
// blocks are BLOCK_W bits (8 bytes), addresses are byte addresses
// CNT_W must be at least LOG_QUEUE_SIZE+1 of the queue instance
package prefetchPkg;

    localparam int ADDR_W  = 32;    // address field width
    localparam int BLOCK_W = 64;    // one data block
    localparam int CNT_W   = 4;     // outstanding prefetch counter, fits LOG_QUEUE_SIZE 3

    // queue command opcodes, same numbering as the older data path
    typedef enum logic [2:0] {
        opNop       = 3'd0,
        opPrefReq   = 3'd1,
        opMasterReq = 3'd2,
        opSlaveData = 3'd3,
        opPop       = 3'd4
    } queueOp;

    typedef enum logic [2:0] {
        errNone     = 3'd0,
        errLost     = 3'd1,     // strobe dropped by the arbiter
        errFull     = 3'd2,     // request while queue full
        errNotReady = 3'd3,     // pop with nothing to return
        errOverflow = 3'd4      // slave beat with no slot waiting
    } errCode;

    typedef struct packed {
        queueOp              op;
        logic [ADDR_W-1:0]   addr;
        logic [BLOCK_W-1:0]  data;  // slave beat, already one cycle late
        logic                last;  // last beat of the slave burst
    } queueCmd;

    typedef struct packed {
        logic             addrHit;
        logic             respValid;
        logic             almostFull;
        logic             hasOutstanding;
        logic [CNT_W-1:0] prefetchReqCnt;
    } queueStatus;

endpackage

// File: blockMatch.sv
// address search over the burst heads of the queue
// lowest matching index wins, purely combinational
module blockMatch #(
    parameter int  LOG_QUEUE_SIZE = 3,
    localparam int QUEUE_SIZE     = 1 << LOG_QUEUE_SIZE
) (
    input  logic [prefetchPkg::ADDR_W-1:0] addr,
    input  logic [prefetchPkg::ADDR_W-1:0] blockAddr [QUEUE_SIZE],
    input  logic [QUEUE_SIZE-1:0]          headMask,   // valid burst heads
    output logic                           hit,
    output logic [LOG_QUEUE_SIZE-1:0]     matchIdx
);

    always_comb begin
        hit      = 1'b0;
        matchIdx = '0;
        // scan downward so the lowest match is the one left standing
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (headMask[i] && blockAddr[i] == addr) begin
                hit      = 1'b1;
                matchIdx = LOG_QUEUE_SIZE'(i);
            end
        end
    end

endmodule

// File: prefetchQueue.sv
// burst queue of the prefetcher, one command per cycle
// QUEUE_SIZE must be a multiple of BURST_LEN so bursts never straddle the wrap
// slave beats fill blocks strictly in allocation order
// a zero-promise head is only skipped when the next burst can be popped
module prefetchQueue #(
    parameter int  LOG_QUEUE_SIZE = 3,
    parameter int  BURST_LEN      = 2,
    parameter int  PROMISE_WIDTH  = 3,
    localparam int QUEUE_SIZE     = 1 << LOG_QUEUE_SIZE
) (
    input  logic                            clk,
    input  logic                            resetN,
    input  prefetchPkg::queueCmd            cmd,
    input  logic                            lostCmd,
    input  logic [LOG_QUEUE_SIZE-1:0]       almostFullSpacer,  // in bursts
    output prefetchPkg::queueStatus         status,
    output logic [prefetchPkg::BLOCK_W-1:0] respData,
    output logic                            respLast,
    output prefetchPkg::errCode             errorCode
);

    localparam int VCNT_W = LOG_QUEUE_SIZE + 1;
    localparam logic [LOG_QUEUE_SIZE-1:0] BURST_STEP = LOG_QUEUE_SIZE'(BURST_LEN);

    logic [prefetchPkg::BLOCK_W-1:0] dataMat [QUEUE_SIZE];
    logic [prefetchPkg::ADDR_W-1:0]  blockAddr [QUEUE_SIZE];   // meaningful at heads only
    logic [PROMISE_WIDTH-1:0]        promiseCnt [QUEUE_SIZE];  // kept per head
    logic [QUEUE_SIZE-1:0] validVec, dataValidVec, lastVec;
    logic [QUEUE_SIZE-1:0] addrValid;     // set on burst heads
    logic [QUEUE_SIZE-1:0] prefetchVec;   // head allocated by prefetch and not yet asked for
    logic [LOG_QUEUE_SIZE-1:0] headPtr, tailPtr, readDataPtr, burstOffset;
    logic [LOG_QUEUE_SIZE-1:0] curIdx, nextHead, popBase, popIdx, matchIdx;
    logic [VCNT_W-1:0]               validCnt;
    logic [prefetchPkg::CNT_W-1:0]   prefCnt;
    logic addrHit, isFull, curReady, nextReady, respValid;
    logic allocate, slaveOk;

    blockMatch #(.LOG_QUEUE_SIZE(LOG_QUEUE_SIZE)) headSearch (
        .addr     (cmd.addr),
        .blockAddr(blockAddr),
        .headMask (validVec & addrValid),
        .hit      (addrHit),
        .matchIdx (matchIdx)
    );

    always_comb begin
        validCnt = '0;
        prefCnt  = '0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            validCnt = validCnt + VCNT_W'(validVec[i]);
            prefCnt  = prefCnt + prefetchPkg::CNT_W'(prefetchVec[i]);
        end

        curIdx    = headPtr + burstOffset;
        nextHead  = headPtr + BURST_STEP;
        curReady  = validVec[curIdx] && dataValidVec[curIdx] && promiseCnt[headPtr] != '0;
        nextReady = validVec[nextHead] && dataValidVec[nextHead] && promiseCnt[nextHead] != '0;
        respValid = curReady || (promiseCnt[headPtr] == '0 && nextReady);
        popBase   = curReady ? headPtr : nextHead;   // skip an unpromised head
        popIdx    = popBase + burstOffset;

        isFull   = (VCNT_W'(QUEUE_SIZE) - validCnt) < VCNT_W'(BURST_LEN);
        allocate = (cmd.op == prefetchPkg::opMasterReq || cmd.op == prefetchPkg::opPrefReq)
                   && !addrHit && !isFull;
        slaveOk  = validVec[readDataPtr] && !dataValidVec[readDataPtr];

        status.addrHit        = addrHit;
        status.respValid      = respValid;
        status.almostFull     = 32'(validCnt) + 32'(almostFullSpacer) * 32'(BURST_LEN)
                                >= 32'(QUEUE_SIZE);
        status.hasOutstanding = |(validVec & ~dataValidVec);  // blocks still waiting for DRAM
        status.prefetchReqCnt = prefCnt;
        respData = dataMat[popIdx];
        respLast = lastVec[popIdx];
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (cmd.op == prefetchPkg::opSlaveData && slaveOk) begin
            dataMat[readDataPtr] <= cmd.data;
        end
        if (allocate) begin
            blockAddr[tailPtr] <= cmd.addr;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            validVec     <= '0;
            dataValidVec <= '0;
            lastVec      <= '0;
            addrValid    <= '0;
            prefetchVec  <= '0;
            headPtr      <= '0;
            tailPtr      <= '0;
            readDataPtr  <= '0;
            burstOffset  <= '0;
            errorCode    <= prefetchPkg::errNone;
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                promiseCnt[i] <= '0;
            end
        end else begin
            errorCode <= prefetchPkg::errNone;   // one-cycle report
            case (cmd.op)
                prefetchPkg::opPrefReq, prefetchPkg::opMasterReq: begin
                    if (cmd.op == prefetchPkg::opMasterReq && addrHit) begin
                        promiseCnt[matchIdx]  <= promiseCnt[matchIdx] + 1'b1;
                        prefetchVec[matchIdx] <= 1'b0;   // prefetch now promised
                    end else if (allocate) begin
                        for (int k = 0; k < BURST_LEN; k++) begin
                            validVec[tailPtr + LOG_QUEUE_SIZE'(k)]     <= 1'b1;
                            dataValidVec[tailPtr + LOG_QUEUE_SIZE'(k)] <= 1'b0;
                            addrValid[tailPtr + LOG_QUEUE_SIZE'(k)]    <= 1'b0;
                        end
                        addrValid[tailPtr]   <= 1'b1;
                        prefetchVec[tailPtr] <= (cmd.op == prefetchPkg::opPrefReq);
                        promiseCnt[tailPtr]  <= (cmd.op == prefetchPkg::opMasterReq)
                                                ? PROMISE_WIDTH'(1) : '0;
                        tailPtr <= tailPtr + BURST_STEP;
                    end else if (!addrHit) begin
                        errorCode <= prefetchPkg::errFull;
                    end
                    // a prefetch hit is already queued and needs nothing
                end
                prefetchPkg::opSlaveData: begin
                    if (slaveOk) begin
                        dataValidVec[readDataPtr] <= 1'b1;
                        lastVec[readDataPtr]      <= cmd.last;
                        readDataPtr               <= readDataPtr + 1'b1;
                    end else begin
                        errorCode <= prefetchPkg::errOverflow;
                    end
                end
                prefetchPkg::opPop: begin
                    if (!respValid) begin
                        errorCode <= prefetchPkg::errNotReady;
                    end else begin
                        if (!curReady) begin   // free the zero-promise head
                            for (int k = 0; k < BURST_LEN; k++) begin
                                validVec[headPtr + LOG_QUEUE_SIZE'(k)] <= 1'b0;
                            end
                            addrValid[headPtr]   <= 1'b0;
                            prefetchVec[headPtr] <= 1'b0;
                            headPtr              <= nextHead;
                        end
                        if (lastVec[popIdx]) begin
                            promiseCnt[popBase] <= promiseCnt[popBase] - 1'b1;  // promise served
                            burstOffset         <= '0;
                        end else begin
                            burstOffset <= burstOffset + 1'b1;
                        end
                    end
                end
                default: ;   // opNop
            endcase
            if (lostCmd) begin
                errorCode <= prefetchPkg::errLost;
            end
        end
    end

endmodule

// File: nextLinePrefetcher.sv
// next-line prefetch engine, one pending request at most
// a newer master miss replaces the pending one
// nothing is offered while the queue reports almostFull
module nextLinePrefetcher #(
    parameter int BURST_LEN = 2
) (
    input  logic                           clk,
    input  logic                           resetN,
    input  logic                           masterReq,
    input  logic [prefetchPkg::ADDR_W-1:0] masterAddr,
    input  prefetchPkg::queueStatus        status,
    input  logic                           prefGrant,
    output logic                           prefValid,
    output logic [prefetchPkg::ADDR_W-1:0] prefAddr
);

    // bytes covered by one burst
    localparam logic [prefetchPkg::ADDR_W-1:0] LINE_STEP =
        prefetchPkg::ADDR_W'(BURST_LEN * (prefetchPkg::BLOCK_W / 8));

    logic pending;
    logic masterMiss;

    assign masterMiss = masterReq && !status.addrHit;   // hit is searched on masterAddr

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pending <= 1'b0;
        end else if (masterMiss) begin
            pending <= 1'b1;
        end else if (prefGrant || status.almostFull) begin
            pending <= 1'b0;   // sent, or dropped near full
        end
    end

    always_ff @(posedge clk) begin
        if (masterMiss) begin
            prefAddr <= masterAddr + LINE_STEP;
        end
    end

    // hidden while almostFull so the arbiter never grants a dropped request
    assign prefValid = pending && !status.almostFull;

endmodule

// File: queueArbiter.sv
// fixed priority merge onto the single queue command port
// order is slave data, master request, pop, prefetch
// slave beats are delayed one cycle, losers are dropped and flagged
module queueArbiter (
    input  logic                            clk,
    input  logic                            resetN,
    input  logic                            slaveValid,
    input  logic                            slaveLast,
    input  logic [prefetchPkg::BLOCK_W-1:0] slaveData,
    input  logic                            masterReq,
    input  logic                            masterPop,
    input  logic [prefetchPkg::ADDR_W-1:0]  masterAddr,
    input  logic                            prefValid,
    input  logic [prefetchPkg::ADDR_W-1:0]  prefAddr,
    output prefetchPkg::queueCmd            cmd,
    output logic                            prefGrant,
    output logic                            lostCmd
);

    logic                            slaveValidD;
    logic                            slaveLastD;
    logic [prefetchPkg::BLOCK_W-1:0] slaveDataD;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) slaveValidD <= 1'b0;
        else         slaveValidD <= slaveValid;
    end

    always_ff @(posedge clk) begin
        slaveDataD <= slaveData;   // captured every cycle
        slaveLastD <= slaveLast;
    end

    always_comb begin
        prefGrant = prefValid && !slaveValidD && !masterReq && !masterPop;
        lostCmd   = (masterReq && slaveValidD) || (masterPop && (slaveValidD || masterReq));
        cmd.data  = slaveDataD;
        cmd.last  = slaveLastD;
        cmd.addr  = prefGrant ? prefAddr : masterAddr;   // master addr drives the hit search
        if (slaveValidD)    cmd.op = prefetchPkg::opSlaveData;
        else if (masterReq) cmd.op = prefetchPkg::opMasterReq;
        else if (masterPop) cmd.op = prefetchPkg::opPop;
        else if (prefValid) cmd.op = prefetchPkg::opPrefReq;
        else                cmd.op = prefetchPkg::opNop;
    end

endmodule

// File: prefetcherTop.sv
// read prefetcher top, no back-pressure toward master or slave
// at most one of masterReq, masterPop, slaveValid per cycle is expected
module prefetcherTop #(
    parameter int LOG_QUEUE_SIZE = 3,
    parameter int BURST_LEN      = 2,
    parameter int PROMISE_WIDTH  = 3
) (
    input  logic                            clk,
    input  logic                            resetN,
    input  logic                            masterReq,
    input  logic [prefetchPkg::ADDR_W-1:0]  masterAddr,
    input  logic                            masterPop,
    input  logic                            slaveValid,
    input  logic [prefetchPkg::BLOCK_W-1:0] slaveData,
    input  logic                            slaveLast,
    input  logic [LOG_QUEUE_SIZE-1:0]       almostFullSpacer,
    output logic                            respValid,
    output logic [prefetchPkg::BLOCK_W-1:0] respData,
    output logic                            respLast,
    output logic                            addrHit,
    output logic                            almostFull,
    output logic                            hasOutstanding,
    output logic [prefetchPkg::CNT_W-1:0]   prefetchReqCnt,
    output prefetchPkg::errCode             errorCode
);

    prefetchPkg::queueCmd           cmd;
    prefetchPkg::queueStatus        status;
    logic                           prefValid, prefGrant, lostCmd;
    logic [prefetchPkg::ADDR_W-1:0] prefAddr;

    queueArbiter arbiter (
        .clk(clk), .resetN(resetN),
        .slaveValid(slaveValid), .slaveLast(slaveLast), .slaveData(slaveData),
        .masterReq(masterReq), .masterPop(masterPop), .masterAddr(masterAddr),
        .prefValid(prefValid), .prefAddr(prefAddr),
        .cmd(cmd), .prefGrant(prefGrant), .lostCmd(lostCmd)
    );

    nextLinePrefetcher #(.BURST_LEN(BURST_LEN)) prefetcher (
        .clk(clk), .resetN(resetN),
        .masterReq(masterReq), .masterAddr(masterAddr),
        .status(status), .prefGrant(prefGrant),
        .prefValid(prefValid), .prefAddr(prefAddr)
    );

    prefetchQueue #(
        .LOG_QUEUE_SIZE(LOG_QUEUE_SIZE), .BURST_LEN(BURST_LEN), .PROMISE_WIDTH(PROMISE_WIDTH)
    ) queue (
        .clk(clk), .resetN(resetN),
        .cmd(cmd), .lostCmd(lostCmd), .almostFullSpacer(almostFullSpacer),
        .status(status), .respData(respData), .respLast(respLast), .errorCode(errorCode)
    );

    // status fields out to ports
    assign respValid      = status.respValid;
    assign addrHit        = status.addrHit;
    assign almostFull     = status.almostFull;
    assign hasOutstanding = status.hasOutstanding;
    assign prefetchReqCnt = status.prefetchReqCnt;

endmodule

// File: prefetcherTb.sv
// replays prefetchGolden.txt one line per clock cycle
// expected outputs come only from the file, nothing is modelled here
// inputs change on the falling edge, outputs checked just before the next one
// respData is compared only when the expected respValid is high
module prefetcherTb;

    localparam int LOG_QUEUE_SIZE = 3;
    localparam int FIELDS     = 16;     // words per golden line
    localparam int MAX_LINES  = 40;
    localparam int MAX_CYCLES = 36;     // replay limit, below MAX_LINES

    // word positions inside one golden line
    localparam int KIND     = 0;
    localparam int S_REQ    = 1;
    localparam int S_ADDR   = 2;
    localparam int S_POP    = 3;
    localparam int S_VALID  = 4;
    localparam int S_DATA   = 5;
    localparam int S_LAST   = 6;
    localparam int S_SPACER = 7;
    localparam int E_VALID  = 8;
    localparam int E_DATA   = 9;
    localparam int E_LAST   = 10;
    localparam int E_HIT    = 11;
    localparam int E_AFULL  = 12;
    localparam int E_OUTST  = 13;
    localparam int E_PCNT   = 14;
    localparam int E_ERR    = 15;

    logic                            clk;
    logic                            resetN;
    logic                            masterReq;
    logic                            masterPop;
    logic [prefetchPkg::ADDR_W-1:0]  masterAddr;
    logic                            slaveValid;
    logic                            slaveLast;
    logic [prefetchPkg::BLOCK_W-1:0] slaveData;
    logic [LOG_QUEUE_SIZE-1:0]       almostFullSpacer;
    logic                            respValid, respLast, addrHit;
    logic                            almostFull, hasOutstanding;
    logic [prefetchPkg::BLOCK_W-1:0] respData;
    logic [prefetchPkg::CNT_W-1:0]   prefetchReqCnt;
    prefetchPkg::errCode             errorCode;

    logic [63:0] golden [MAX_LINES*FIELDS];   // flat, FIELDS words per line
    int          errorCount;
    int          checkCount;
    int          cycle;

    prefetcherTop #(
        .LOG_QUEUE_SIZE(LOG_QUEUE_SIZE), .BURST_LEN(2), .PROMISE_WIDTH(3)
    ) uut (
        .clk(clk), .resetN(resetN),
        .masterReq(masterReq), .masterAddr(masterAddr), .masterPop(masterPop),
        .slaveValid(slaveValid), .slaveData(slaveData), .slaveLast(slaveLast),
        .almostFullSpacer(almostFullSpacer),
        .respValid(respValid), .respData(respData), .respLast(respLast),
        .addrHit(addrHit), .almostFull(almostFull), .hasOutstanding(hasOutstanding),
        .prefetchReqCnt(prefetchReqCnt), .errorCode(errorCode)
    );

    always #5 clk = ~clk;

    function automatic logic [63:0] goldenWord(input int line, input int field);
        if (line >= MAX_LINES) return '0;   // past the table reads as end
        return golden[line*FIELDS + field];
    endfunction

    task automatic applyStimulus(input int line);
        masterReq        = 1'(goldenWord(line, S_REQ));
        masterAddr       = prefetchPkg::ADDR_W'(goldenWord(line, S_ADDR));
        masterPop        = 1'(goldenWord(line, S_POP));
        slaveValid       = 1'(goldenWord(line, S_VALID));
        slaveData        = goldenWord(line, S_DATA);
        slaveLast        = 1'(goldenWord(line, S_LAST));
        almostFullSpacer = LOG_QUEUE_SIZE'(goldenWord(line, S_SPACER));
    endtask

    task automatic compareField(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic checkOutputs(input int line);
        logic [63:0] expValid;
        expValid = goldenWord(line, E_VALID);
        compareField("respValid", expValid, 64'(respValid));
        if (expValid[0]) begin   // data is only meaningful while valid
            compareField("respData", goldenWord(line, E_DATA), respData);
            compareField("respLast", goldenWord(line, E_LAST), 64'(respLast));
        end
        compareField("addrHit", goldenWord(line, E_HIT), 64'(addrHit));
        compareField("almostFull", goldenWord(line, E_AFULL), 64'(almostFull));
        compareField("hasOutstanding", goldenWord(line, E_OUTST), 64'(hasOutstanding));
        compareField("prefetchReqCnt", goldenWord(line, E_PCNT), 64'(prefetchReqCnt));
        compareField("errorCode", goldenWord(line, E_ERR), 64'(errorCode));
    endtask

    initial begin
        clk              = 1'b0;
        resetN           = 1'b0;
        masterReq        = 1'b0;
        masterPop        = 1'b0;
        masterAddr       = '0;
        slaveValid       = 1'b0;
        slaveLast        = 1'b0;
        slaveData        = '0;
        almostFullSpacer = '0;
        errorCount       = 0;
        checkCount       = 0;
        cycle            = 0;

        $readmemh("prefetchGolden.txt", golden);
        repeat (2) @(negedge clk);   // two cycles in reset
        resetN = 1'b1;

        if (goldenWord(0, KIND) !== 64'd1) begin
            $display("golden file is missing or holds no cycle lines");
            errorCount++;
        end

        // one golden line per cycle until the end line
        while (goldenWord(cycle, KIND) === 64'd1 && cycle < MAX_CYCLES) begin
            applyStimulus(cycle);
            @(posedge clk);
            #4;                      // outputs settled, next falling edge not yet reached
            checkOutputs(cycle);
            @(negedge clk);
            cycle++;
        end
        if (goldenWord(cycle, KIND) === 64'd1) begin
            $display("timeout: golden file still had cycle lines after %0d cycles", cycle);
            errorCount++;
        end

        $display("cycles %0d, checks %0d, errors %0d", cycle, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: prefetchGolden.txt
// kind mReq mAddr mPop sValid sData sLast spacer | respValid respData respLast addrHit
// almostFull hasOutstanding prefetchReqCnt errorCode, all hex; kind 1 is a cycle, 0 ends
// master miss, two beats, two pops
1 1 00000100 0 0 0 0 0   0 0 0 1 0 1 0 0    // miss on 0x100, burst at block 0
1 0 00000000 0 0 0 0 0   0 0 0 0 0 1 1 0    // next line 0x110 granted
1 0 00000000 0 1 1000000000000100 0 0   0 0 0 0 0 1 1 0
1 0 00000000 0 1 1000000000000108 1 0   1 1000000000000100 0 0 0 1 1 0
1 0 00000000 0 0 0 0 0   1 1000000000000100 0 0 0 1 1 0    // last beat lands
1 0 00000000 1 0 0 0 0   1 1000000000000108 1 0 0 1 1 0    // first pop
1 0 00000000 1 0 0 0 0   0 0 0 0 0 1 1 0    // second pop, promise used up
// master hit on the prefetched burst, then zero-promise head skipped
1 1 00000110 0 0 0 0 0   0 0 0 1 0 1 0 0
1 0 00000000 0 1 2000000000000110 0 0   0 0 0 0 0 1 0 0
1 0 00000000 0 1 2000000000000118 1 0   1 2000000000000110 0 0 0 1 0 0
1 0 00000000 0 0 0 0 0   1 2000000000000110 0 0 0 0 0 0
1 0 00000000 1 0 0 0 0   1 2000000000000118 1 0 0 0 0 0    // pop frees head 0
1 0 00000000 1 0 0 0 0   0 0 0 0 0 0 0 0
// error codes
1 0 00000000 1 0 0 0 0   0 0 0 0 0 0 0 3    // pop while not ready
1 0 00000000 0 1 dead0000beef0000 0 0   0 0 0 0 0 0 0 0
1 0 00000000 0 0 0 0 0   0 0 0 0 0 0 0 4    // beat with no slot
1 1 00000200 1 0 0 0 0   0 0 0 1 0 1 0 1    // req wins, pop lost
1 0 00000000 0 0 0 0 0   0 0 0 0 0 1 1 0    // prefetch 0x210 granted
// spacer 1, almostFull at six blocks
1 0 00000000 0 0 0 0 1   0 0 0 0 1 1 1 0
1 1 00000300 0 0 0 0 1   0 0 0 1 1 1 1 0    // fills the queue
1 0 00000000 0 0 0 0 1   0 0 0 0 1 1 1 0    // pending 0x310 dropped
1 1 00000400 0 0 0 0 1   0 0 0 0 1 1 1 2    // request to a full queue
1 0 00000000 0 0 0 0 0   0 0 0 0 1 1 1 0
0    // end of replay

// File: all.f
prefetchPkg.sv
blockMatch.sv
prefetchQueue.sv
nextLinePrefetcher.sv
queueArbiter.sv
prefetcherTop.sv
prefetcherTb.sv

// File: Makefile
# Verilator build for the read prefetcher, run from the project root
VERILATOR ?= verilator
TOP       ?= prefetcherTb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# status comes from the search for the pass line in the simulation output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
